// ==== verilog/batch_pkg.sv ====
package batch_pkg;

    // Number of tracked resources per dependency vector
    localparam int dep_width = 16;

    // Owner program ID width
    localparam int id_width = 64;

    // One bit per tracked resource
    typedef logic [dep_width-1:0] dep_vec_t;

    // One scheduled transaction
    typedef struct packed {
        logic [id_width-1:0] program_id;
        dep_vec_t            read_deps;
        dep_vec_t            write_deps;
    } txn_t;

    // Footprint of a flushed batch
    typedef struct packed {
        logic [7:0] entry_count;
        dep_vec_t   read_union;
        dep_vec_t   write_union;
    } batch_summary_t;

    // Sequencer states
    typedef enum logic [1:0] {
        collect = 2'd0,
        drain   = 2'd1,
        done    = 2'd2
    } seq_state_e;

endpackage

// ==== verilog/batch_buffer.sv ====
`timescale 1ns/10ps

module batch_buffer #(
    parameter int max_batch = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_en,
    input  batch_pkg::txn_t                wr_txn,
    input  logic                           rd_adv,
    input  logic                           clear,
    output batch_pkg::txn_t                head_txn,
    output logic [$clog2(max_batch+1)-1:0] entry_count,
    output logic                           full,
    output logic                           last,
    output batch_pkg::dep_vec_t            read_union,
    output batch_pkg::dep_vec_t            write_union
);

    localparam int cnt_w = $clog2(max_batch + 1);
    localparam int idx_w = (max_batch > 1) ? $clog2(max_batch) : 1;

    batch_pkg::txn_t  entries [max_batch];
    logic [cnt_w-1:0] rd_pos;
    logic [idx_w-1:0] wr_idx;
    logic [idx_w-1:0] rd_idx;

    // Entries are written in order, so the count is also the write slot
    assign wr_idx = entry_count[idx_w-1:0];
    assign rd_idx = rd_pos[idx_w-1:0];

    assign head_txn = entries[rd_idx];
    assign full     = (entry_count == cnt_w'(max_batch));
    assign last     = ((rd_pos + cnt_w'(1)) == entry_count);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_idx] <= wr_txn;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_count <= '0;
            rd_pos      <= '0;
            read_union  <= '0;
            write_union <= '0;
        end else if (clear) begin
            entry_count <= '0;
            rd_pos      <= '0;
            read_union  <= '0;
            write_union <= '0;
        end else begin
            if (wr_en) begin
                entry_count <= entry_count + cnt_w'(1);
                // Accumulate the batch footprint as entries arrive
                read_union  <= read_union | wr_txn.read_deps;
                write_union <= write_union | wr_txn.write_deps;
            end
            if (rd_adv) begin
                rd_pos <= rd_pos + cnt_w'(1);
            end
        end
    end

    // Upstream must stop accepting once the batch is full
    assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full)
        else $error("batch_buffer write while full");

    // A replay beat needs a stored entry behind it
    assert property (@(posedge clk) disable iff (!rst_n) rd_adv |-> (entry_count != '0))
        else $error("batch_buffer read advance on empty batch");

endmodule

// ==== verilog/flush_timer.sv ====
`timescale 1ns/10ps

module flush_timer #(
    parameter int max_batch      = 8,
    parameter int min_batch      = 2,
    parameter int timeout_cycles = 100
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           collecting,
    input  logic                           wr_en,
    input  logic [$clog2(max_batch+1)-1:0] entry_count,
    output logic                           flush
);

    localparam int cnt_w = $clog2(max_batch + 1);
    localparam int tmr_w = $clog2(2 * timeout_cycles + 1);

    logic [tmr_w-1:0] idle_cnt;
    logic             has_entries;
    logic             enough_entries;

    assign has_entries    = (entry_count != '0);
    assign enough_entries = (entry_count >= cnt_w'(min_batch));

    // Idle cycles of a nonempty batch still being collected
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle_cnt <= '0;
        end else if (!collecting || wr_en || !has_entries) begin
            idle_cnt <= '0;
        end else if (idle_cnt != tmr_w'(2 * timeout_cycles)) begin
            idle_cnt <= idle_cnt + tmr_w'(1);
        end
    end

    // Small batches get twice the wait before they are sent on
    always_comb begin
        flush = 1'b0;
        if (collecting) begin
            if (enough_entries) begin
                flush = (idle_cnt == tmr_w'(timeout_cycles));
            end else begin
                flush = (idle_cnt == tmr_w'(2 * timeout_cycles));
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) flush |-> has_entries)
        else $error("flush_timer flush with empty batch");

endmodule

// ==== verilog/batch_sequencer.sv ====
`timescale 1ns/10ps

module batch_sequencer #(
    parameter int max_batch = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    output logic                           in_ready,
    output logic                           out_valid,
    input  logic                           out_ready,
    input  logic                           full,
    input  logic                           last,
    input  logic                           flush,
    input  logic [$clog2(max_batch+1)-1:0] entry_count,
    input  batch_pkg::dep_vec_t            read_union,
    input  batch_pkg::dep_vec_t            write_union,
    output logic                           wr_en,
    output logic                           rd_adv,
    output logic                           clear,
    output logic                           collecting,
    output logic                           batch_done,
    output batch_pkg::batch_summary_t      summary,
    output logic [31:0]                    transactions_batched
);

    localparam int cnt_w = $clog2(max_batch + 1);

    batch_pkg::seq_state_e state;
    batch_pkg::seq_state_e state_nxt;
    logic                  fill_accept;
    logic                  last_beat;

    assign collecting = (state == batch_pkg::collect);
    assign in_ready   = collecting && !full;
    assign wr_en      = in_valid && in_ready;

    // The accept that brings the count up to max_batch
    assign fill_accept = wr_en && (entry_count == cnt_w'(max_batch - 1));

    assign out_valid  = (state == batch_pkg::drain);
    assign rd_adv     = out_valid && out_ready;
    assign last_beat  = rd_adv && last;

    assign batch_done = (state == batch_pkg::done);
    assign clear      = batch_done;

    always_comb begin
        state_nxt = state;
        case (state)
            batch_pkg::collect: begin
                if (full || flush || fill_accept) begin
                    state_nxt = batch_pkg::drain;
                end
            end
            batch_pkg::drain: begin
                if (last_beat) begin
                    state_nxt = batch_pkg::done;
                end
            end
            batch_pkg::done: begin
                state_nxt = batch_pkg::collect;
            end
            default: begin
                state_nxt = batch_pkg::collect;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= batch_pkg::collect;
        end else begin
            state <= state_nxt;
        end
    end

    // Summary is loaded on the final beat so it is valid with batch_done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            summary <= '0;
        end else if (last_beat) begin
            summary <= '{
                entry_count: 8'(entry_count),
                read_union:  read_union,
                write_union: write_union
            };
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            transactions_batched <= '0;
        end else if (rd_adv) begin
            transactions_batched <= transactions_batched + 32'd1;
        end
    end

    // Valid stays up until the beat is taken
    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> out_valid)
        else $error("batch_sequencer out_valid dropped without transfer");

endmodule

// ==== verilog/batch_top.sv ====
`timescale 1ns/10ps

module batch_top #(
    parameter int max_batch      = 8,
    parameter int min_batch      = 2,
    parameter int timeout_cycles = 100
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  batch_pkg::txn_t           in_txn,
    output logic                      out_valid,
    input  logic                      out_ready,
    output batch_pkg::txn_t           out_txn,
    output logic                      batch_done,
    output batch_pkg::batch_summary_t summary,
    output logic [31:0]               transactions_batched
);

    localparam int cnt_w = $clog2(max_batch + 1);

    logic                wr_en;
    logic                rd_adv;
    logic                clear;
    logic                collecting;
    logic                full;
    logic                last;
    logic                flush;
    logic [cnt_w-1:0]    entry_count;
    batch_pkg::dep_vec_t read_union;
    batch_pkg::dep_vec_t write_union;
    batch_pkg::txn_t     head_txn;

    // Replay data comes straight from the entry at the read index
    assign out_txn = head_txn;

    batch_buffer #(
        .max_batch (max_batch)
    ) i_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_txn      (in_txn),
        .rd_adv      (rd_adv),
        .clear       (clear),
        .head_txn    (head_txn),
        .entry_count (entry_count),
        .full        (full),
        .last        (last),
        .read_union  (read_union),
        .write_union (write_union)
    );

    flush_timer #(
        .max_batch      (max_batch),
        .min_batch      (min_batch),
        .timeout_cycles (timeout_cycles)
    ) i_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .collecting  (collecting),
        .wr_en       (wr_en),
        .entry_count (entry_count),
        .flush       (flush)
    );

    batch_sequencer #(
        .max_batch (max_batch)
    ) i_sequencer (
        .clk                  (clk),
        .rst_n                (rst_n),
        .in_valid             (in_valid),
        .in_ready             (in_ready),
        .out_valid            (out_valid),
        .out_ready            (out_ready),
        .full                 (full),
        .last                 (last),
        .flush                (flush),
        .entry_count          (entry_count),
        .read_union           (read_union),
        .write_union          (write_union),
        .wr_en                (wr_en),
        .rd_adv               (rd_adv),
        .clear                (clear),
        .collecting           (collecting),
        .batch_done           (batch_done),
        .summary              (summary),
        .transactions_batched (transactions_batched)
    );

endmodule

// ==== tests/batch_top_tb.sv ====
`timescale 1ns/10ps

module batch_top_tb;

    localparam int max_batch      = 8;
    localparam int min_batch      = 2;
    localparam int timeout_cycles = 100;
    localparam int n_rows         = 6;

    // Stimulus table with the expected number of batches per row
    string row_name    [n_rows] = '{"full_batch", "normal_timeout", "extended_timeout",
                                    "backpressure", "two_batches", "min_batch_timeout"};
    int    row_txns    [n_rows] = '{8, 3, 1, 8, 12, 2};
    int    row_gap     [n_rows] = '{2, 0, 0, 3, 0, 5};
    bit    row_rand    [n_rows] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
    int    row_batches [n_rows] = '{1, 1, 1, 1, 2, 1};

    logic clk;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    logic out_valid;
    logic out_ready;
    logic batch_done;
    logic rand_ready;
    logic [31:0] transactions_batched;
    batch_pkg::txn_t in_txn;
    batch_pkg::txn_t out_txn;
    batch_pkg::batch_summary_t summary;

    integer seed = 32'hc941b7c7;
    int errors = 0;
    int cycle = 0;
    int out_total = 0;
    int cur_cnt = 0;
    int beats = 0;
    int batches_seen = 0;
    int last_accept = 0;
    int exp_gap;
    string cur_name = "reset";
    batch_pkg::dep_vec_t cur_rd = '0;
    batch_pkg::dep_vec_t cur_wr = '0;
    batch_pkg::txn_t exp_q [$];
    batch_pkg::txn_t pool [$];
    batch_pkg::txn_t exp_t;
    batch_pkg::txn_t prev_out;
    batch_pkg::batch_summary_t exp_sum;
    batch_pkg::batch_summary_t held_sum = '0;
    bit prev_stall = 1'b0;
    bit prev_valid = 1'b0;
    bit prev_done = 1'b0;

    batch_top i_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .in_valid             (in_valid),
        .in_ready             (in_ready),
        .in_txn               (in_txn),
        .out_valid            (out_valid),
        .out_ready            (out_ready),
        .out_txn              (out_txn),
        .batch_done           (batch_done),
        .summary              (summary),
        .transactions_batched (transactions_batched)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic batch_pkg::txn_t random_txn();
        batch_pkg::txn_t t;
        t.program_id = {$random(seed), $random(seed)};
        // Sparse vectors keep the unions from saturating
        t.read_deps  = 16'($random(seed) & $random(seed));
        t.write_deps = 16'($random(seed) & $random(seed) & $random(seed));
        return t;
    endfunction

    function automatic int cycle_limit();
        int total;
        total = 200;
        for (int r = 0; r < n_rows; r++) begin
            total += row_gap[r] + 4 * row_txns[r] + row_batches[r] * (2 * timeout_cycles + 20);
        end
        return total;
    endfunction

    task automatic report_mismatch(input string what, input logic [95:0] exp,
                                   input logic [95:0] act);
        errors++;
        $display("FAILED %s %s: expected %0h actual %0h", cur_name, what, exp, act);
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("Error in %s: %s", cur_name, msg);
    endtask

    task automatic send_txn(input batch_pkg::txn_t t);
        in_valid <= 1'b1;
        in_txn   <= t;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (rand_ready) out_ready <= 1'($random(seed));
        else out_ready <= 1'b1;
    end

    // Scoreboard sampled mid-cycle where all DUT outputs are settled
    always @(negedge clk) begin
        cycle++;
        if (rst_n) begin
            if (transactions_batched != out_total)
                report_mismatch("total", out_total, transactions_batched);
            if (prev_stall && !out_valid) note_error("out_valid dropped under back-pressure");
            if (prev_stall && out_txn != prev_out)
                report_mismatch("held out_txn", prev_out, out_txn);
            if (cur_cnt == max_batch && in_ready) note_error("in_ready high with a full batch");
            if (prev_done && !in_ready) note_error("in_ready low after batch end");
            if (batch_done) begin
                if (prev_done) note_error("batch_done longer than one cycle");
                exp_sum = '{entry_count: 8'(cur_cnt), read_union: cur_rd, write_union: cur_wr};
                if (summary != exp_sum) report_mismatch("summary", exp_sum, summary);
                if (beats != cur_cnt) report_mismatch("batch beats", cur_cnt, beats);
                held_sum = summary;
                batches_seen++;
                cur_cnt = 0;
                cur_rd  = '0;
                cur_wr  = '0;
                beats   = 0;
            end else if (summary != held_sum) begin
                report_mismatch("summary hold", held_sum, summary);
            end
            // Idle cycles since the last accept decide when the batch leaves
            if (out_valid && !prev_valid) begin
                if (cur_cnt == max_batch) exp_gap = 1;
                else if (cur_cnt >= min_batch) exp_gap = timeout_cycles + 2;
                else exp_gap = 2 * timeout_cycles + 2;
                if (cycle - last_accept != exp_gap)
                    report_mismatch("flush delay", exp_gap, cycle - last_accept);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    note_error("output beat with no transaction sent");
                end else begin
                    exp_t = exp_q.pop_front();
                    if (out_txn != exp_t) report_mismatch("out_txn", exp_t, out_txn);
                end
                out_total++;
                beats++;
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(in_txn);
                cur_cnt++;
                cur_rd |= in_txn.read_deps;
                cur_wr |= in_txn.write_deps;
                last_accept = cycle;
            end
            prev_stall = out_valid && !out_ready;
            prev_out   = out_txn;
            prev_valid = out_valid;
            prev_done  = batch_done;
        end
    end

    initial begin : watchdog
        int limit;
        limit = cycle_limit();
        while (cycle < limit) @(negedge clk);
        $display("Timeout: tests still running after %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        int sent;
        int exp_batches;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_txn     = '0;
        out_ready  = 1'b0;
        rand_ready = 1'b0;
        sent        = 0;
        exp_batches = 0;
        for (int r = 0; r < n_rows; r++) begin
            for (int k = 0; k < row_txns[r]; k++) pool.push_back(random_txn());
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (!in_ready || out_valid || batch_done || summary != '0 || transactions_batched != '0)
            note_error("outputs not at their reset values");
        @(posedge clk);
        for (int r = 0; r < n_rows; r++) begin
            cur_name = row_name[r];
            rand_ready <= row_rand[r];
            exp_batches += row_batches[r];
            for (int k = 0; k < row_txns[r]; k++) begin
                send_txn(pool[sent]);
                sent++;
            end
            in_valid <= 1'b0;
            repeat (row_gap[r]) @(posedge clk);
            while (batches_seen < exp_batches) @(posedge clk);
        end
        repeat (4) @(posedge clk);
        cur_name = "final";
        if (exp_q.size() != 0) note_error("sent transactions never came out");
        if (batches_seen != exp_batches) report_mismatch("batches", exp_batches, batches_seen);
        if (transactions_batched != sent) report_mismatch("total", sent, transactions_batched);
        $display("Tests finished: %0d errors, %0d batches", errors, batches_seen);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== batch_top.f ====
verilog/batch_pkg.sv
verilog/batch_buffer.sv
verilog/flush_timer.sv
verilog/batch_sequencer.sv
verilog/batch_top.sv
tests/batch_top_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f batch_top.f \
		--top-module batch_top_tb -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vbatch_top_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir
